// ==== Bender.yml ====
package:
  name: priv_csr

sources:
  - design/priv_csr_pkg.sv
  - design/csr_access_if.sv
  - design/trap_event_if.sv
  - design/priv_machine_csrs.sv
  - design/priv_debug_csrs.sv
  - design/priv_trap_router.sv
  - design/priv_csr_top.sv
  - target: test
    files:
      - testbench/priv_csr_tb.sv

// ==== design/csr_access_if.sv ====
`timescale 1ns/10ps

interface csr_access_if;

    priv_csr_pkg::csr_addr_t addr;
    priv_csr_pkg::word_t     wdata;
    logic                    write;
    // raised by the block that owns addr
    logic                    hit;
    priv_csr_pkg::word_t     rdata;

    modport router (
        output addr,
        output wdata,
        output write,
        input  hit,
        input  rdata
    );

    modport csrs (
        input  addr,
        input  wdata,
        input  write,
        output hit,
        output rdata
    );

endinterface

// ==== design/priv_csr_pkg.sv ====
package priv_csr_pkg;

    // data word, also used for PCs
    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [1:0]  priv_t;
    typedef logic [4:0]  cause_t;
    typedef logic [2:0]  dbg_cause_t;

    // privilege levels, 2 is reserved
    localparam priv_t PRIV_U = 2'd0;
    localparam priv_t PRIV_S = 2'd1;
    localparam priv_t PRIV_M = 2'd3;

    // trap causes
    localparam cause_t CAUSE_BREAKPOINT = 5'd3;
    // custom interrupt code for a debug halt request
    localparam cause_t CAUSE_DEBUG_HALT = 5'd24;

    // dcsr cause field
    localparam dbg_cause_t DBG_CAUSE_EBREAK  = 3'd1;
    localparam dbg_cause_t DBG_CAUSE_HALTREQ = 3'd3;

    // machine trap csrs
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // debug csrs
    localparam csr_addr_t CSR_DCSR      = 12'h7B0;
    localparam csr_addr_t CSR_DPC       = 12'h7B1;
    localparam csr_addr_t CSR_DSCRATCH0 = 12'h7B2;
    localparam csr_addr_t CSR_DSCRATCH1 = 12'h7B3;

    // external debug support version, dcsr[31:28]
    localparam logic [3:0] DCSR_XDEBUGVER = 4'd4;

    // writable dcsr bits: ebreakm, ebreaks, ebreaku, step, prv
    localparam word_t DCSR_WMASK = 32'h0000_B007;

    // dcsr field positions
    localparam int DCSR_EBREAKM_BIT = 15;
    localparam int DCSR_EBREAKS_BIT = 13;
    localparam int DCSR_EBREAKU_BIT = 12;
    localparam int DCSR_CAUSE_LSB   = 6;

endpackage

// ==== design/priv_csr_top.sv ====
`timescale 1ns/10ps

module priv_csr_top #(
    parameter priv_csr_pkg::word_t DEBUG_BASE = 32'h0000_0800
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  priv_csr_pkg::csr_addr_t csr_addr,
    input  priv_csr_pkg::word_t     csr_wdata,
    input  logic                    csr_write,
    input  logic                    trap,
    input  priv_csr_pkg::word_t     trap_pc,
    input  priv_csr_pkg::cause_t    trap_cause,
    input  logic                    trap_interrupt,
    input  priv_csr_pkg::priv_t     curr_priv,
    input  logic                    dret,
    output priv_csr_pkg::word_t     csr_rdata,
    output logic                    csr_illegal,
    output logic                    redirect_valid,
    output priv_csr_pkg::word_t     redirect_pc,
    output logic                    debug_mode
);

    priv_csr_pkg::word_t mtvec;
    priv_csr_pkg::word_t dpc;
    logic [2:0]          ebreak_en;

    csr_access_if mach_acc ();
    csr_access_if dbg_acc ();
    trap_event_if mach_trap ();
    trap_event_if dbg_trap ();

    priv_machine_csrs u_mach (
        .CLK       (CLK),
        .nRST      (nRST),
        .acc       (mach_acc.csrs),
        .trap_in   (mach_trap.csrs),
        .mtvec_out (mtvec)
    );

    priv_debug_csrs u_dbg (
        .CLK       (CLK),
        .nRST      (nRST),
        .acc       (dbg_acc.csrs),
        .trap_in   (dbg_trap.csrs),
        .dpc_out   (dpc),
        .ebreak_en (ebreak_en)
    );

    priv_trap_router #(
        .DEBUG_BASE (DEBUG_BASE)
    ) u_router (
        .CLK            (CLK),
        .nRST           (nRST),
        .mach_acc       (mach_acc.router),
        .dbg_acc        (dbg_acc.router),
        .mach_trap      (mach_trap.router),
        .dbg_trap       (dbg_trap.router),
        .mtvec          (mtvec),
        .dpc            (dpc),
        .ebreak_en      (ebreak_en),
        .csr_addr       (csr_addr),
        .csr_wdata      (csr_wdata),
        .csr_write      (csr_write),
        .trap           (trap),
        .trap_pc        (trap_pc),
        .trap_cause     (trap_cause),
        .trap_interrupt (trap_interrupt),
        .curr_priv      (curr_priv),
        .dret           (dret),
        .csr_rdata      (csr_rdata),
        .csr_illegal    (csr_illegal),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .debug_mode     (debug_mode)
    );

endmodule

// ==== design/priv_debug_csrs.sv ====
`timescale 1ns/10ps

module priv_debug_csrs (
    input  logic                CLK,
    input  logic                nRST,
    csr_access_if.csrs          acc,
    trap_event_if.csrs          trap_in,
    output priv_csr_pkg::word_t dpc_out,
    output logic [2:0]          ebreak_en
);

    // only the DCSR_WMASK bits are held here
    priv_csr_pkg::word_t      dcsr_ctl;
    priv_csr_pkg::word_t      nxt_ctl;
    priv_csr_pkg::dbg_cause_t dcsr_cause;
    priv_csr_pkg::word_t      dcsr_rd;
    priv_csr_pkg::word_t      dpc;
    priv_csr_pkg::word_t      dscratch0;
    priv_csr_pkg::word_t      dscratch1;
    logic                     wr_en;
    logic                     halt_entry;

    // the hart implements M and U only
    function automatic logic prv_supported(priv_csr_pkg::priv_t p);
        return (p == priv_csr_pkg::PRIV_M) || (p == priv_csr_pkg::PRIV_U);
    endfunction

    assign dcsr_rd = {priv_csr_pkg::DCSR_XDEBUGVER, 28'b0}
                   | dcsr_ctl
                   | {23'b0, dcsr_cause, 6'b0};

    always_comb begin
        acc.hit   = 1'b1;
        acc.rdata = '0;
        case (acc.addr)
            priv_csr_pkg::CSR_DCSR:      acc.rdata = dcsr_rd;
            priv_csr_pkg::CSR_DPC:       acc.rdata = dpc;
            priv_csr_pkg::CSR_DSCRATCH0: acc.rdata = dscratch0;
            priv_csr_pkg::CSR_DSCRATCH1: acc.rdata = dscratch1;
            default: begin
                acc.hit = 1'b0;
            end
        endcase
    end

    assign wr_en      = acc.write && acc.hit;
    assign halt_entry = trap_in.interrupt && (trap_in.cause == priv_csr_pkg::CAUSE_DEBUG_HALT);

    // dcsr control bits, WARL on prv
    always_comb begin
        nxt_ctl = dcsr_ctl;
        if (wr_en && acc.addr == priv_csr_pkg::CSR_DCSR) begin
            nxt_ctl = (dcsr_ctl & ~priv_csr_pkg::DCSR_WMASK)
                    | (acc.wdata & priv_csr_pkg::DCSR_WMASK);
            if (!prv_supported(priv_csr_pkg::priv_t'(nxt_ctl[1:0]))) begin
                nxt_ctl[1:0] = dcsr_ctl[1:0];
            end
        end
        // entry records the level the hart was running at
        if (trap_in.enter && prv_supported(trap_in.prv)) begin
            nxt_ctl[1:0] = trap_in.prv;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dcsr_ctl   <= {30'b0, priv_csr_pkg::PRIV_M};
            dcsr_cause <= '0;
            dpc        <= '0;
            dscratch0  <= '0;
            dscratch1  <= '0;
        end else begin
            dcsr_ctl <= nxt_ctl;
            if (trap_in.enter) begin
                dcsr_cause <= halt_entry ? priv_csr_pkg::DBG_CAUSE_HALTREQ
                                         : priv_csr_pkg::DBG_CAUSE_EBREAK;
                dpc        <= trap_in.epc;
            end else if (wr_en && acc.addr == priv_csr_pkg::CSR_DPC) begin
                dpc <= acc.wdata;
            end
            if (wr_en && acc.addr == priv_csr_pkg::CSR_DSCRATCH0) begin
                dscratch0 <= acc.wdata;
            end
            if (wr_en && acc.addr == priv_csr_pkg::CSR_DSCRATCH1) begin
                dscratch1 <= acc.wdata;
            end
        end
    end

    assign dpc_out   = dpc;
    // M, S, U order
    assign ebreak_en = {dcsr_ctl[priv_csr_pkg::DCSR_EBREAKM_BIT],
                        dcsr_ctl[priv_csr_pkg::DCSR_EBREAKS_BIT],
                        dcsr_ctl[priv_csr_pkg::DCSR_EBREAKU_BIT]};

    prv_legal: assert property (@(posedge CLK) disable iff (!nRST)
        prv_supported(priv_csr_pkg::priv_t'(dcsr_ctl[1:0])))
        else $error("dcsr.prv holds an unsupported level");

endmodule

// ==== design/priv_machine_csrs.sv ====
`timescale 1ns/10ps

module priv_machine_csrs (
    input  logic                CLK,
    input  logic                nRST,
    csr_access_if.csrs          acc,
    trap_event_if.csrs          trap_in,
    output priv_csr_pkg::word_t mtvec_out
);

    priv_csr_pkg::word_t  mtvec;
    priv_csr_pkg::word_t  mscratch;
    priv_csr_pkg::word_t  mepc;
    logic                 mcause_irq;
    priv_csr_pkg::cause_t mcause_code;
    priv_csr_pkg::word_t  mcause_rd;
    logic                 wr_en;

    // interrupt flag on top, code in the low bits
    assign mcause_rd = {mcause_irq, 26'b0, mcause_code};

    // address decode and read mux
    always_comb begin
        acc.hit   = 1'b1;
        acc.rdata = '0;
        case (acc.addr)
            priv_csr_pkg::CSR_MTVEC:    acc.rdata = mtvec;
            priv_csr_pkg::CSR_MSCRATCH: acc.rdata = mscratch;
            priv_csr_pkg::CSR_MEPC:     acc.rdata = mepc;
            priv_csr_pkg::CSR_MCAUSE:   acc.rdata = mcause_rd;
            default: begin
                acc.hit = 1'b0;
            end
        endcase
    end

    assign wr_en = acc.write && acc.hit;

    // mtvec and mscratch only see csr writes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mtvec    <= '0;
            mscratch <= '0;
        end else if (wr_en) begin
            if (acc.addr == priv_csr_pkg::CSR_MTVEC) begin
                // direct mode only, base is word aligned
                mtvec <= {acc.wdata[31:2], 2'b00};
            end
            if (acc.addr == priv_csr_pkg::CSR_MSCRATCH) begin
                mscratch <= acc.wdata;
            end
        end
    end

    // mepc and mcause, trap capture has priority over a write
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mepc        <= '0;
            mcause_irq  <= 1'b0;
            mcause_code <= '0;
        end else if (trap_in.enter) begin
            mepc        <= {trap_in.epc[31:2], 2'b00};
            mcause_irq  <= trap_in.interrupt;
            mcause_code <= trap_in.cause;
        end else if (wr_en) begin
            if (acc.addr == priv_csr_pkg::CSR_MEPC) begin
                mepc <= {acc.wdata[31:2], 2'b00};
            end
            if (acc.addr == priv_csr_pkg::CSR_MCAUSE) begin
                mcause_irq  <= acc.wdata[31];
                mcause_code <= acc.wdata[4:0];
            end
        end
    end

    assign mtvec_out = mtvec;

endmodule

// ==== design/priv_trap_router.sv ====
`timescale 1ns/10ps

module priv_trap_router #(
    parameter priv_csr_pkg::word_t DEBUG_BASE = 32'h0000_0800
) (
    input  logic                      CLK,
    input  logic                      nRST,
    csr_access_if.router              mach_acc,
    csr_access_if.router              dbg_acc,
    trap_event_if.router              mach_trap,
    trap_event_if.router              dbg_trap,
    input  priv_csr_pkg::word_t       mtvec,
    input  priv_csr_pkg::word_t       dpc,
    input  logic [2:0]                ebreak_en,
    input  priv_csr_pkg::csr_addr_t   csr_addr,
    input  priv_csr_pkg::word_t       csr_wdata,
    input  logic                      csr_write,
    input  logic                      trap,
    input  priv_csr_pkg::word_t       trap_pc,
    input  priv_csr_pkg::cause_t      trap_cause,
    input  logic                      trap_interrupt,
    input  priv_csr_pkg::priv_t       curr_priv,
    input  logic                      dret,
    output priv_csr_pkg::word_t       csr_rdata,
    output logic                      csr_illegal,
    output logic                      redirect_valid,
    output priv_csr_pkg::word_t       redirect_pc,
    output logic                      debug_mode
);

    typedef enum logic {RUNNING, HALTED} hart_mode_t;

    hart_mode_t          mode;
    hart_mode_t          nxt_mode;
    priv_csr_pkg::word_t nxt_pc;
    logic                ebreak_hit;
    logic                to_debug;
    logic                running;

    // both blocks see the same access, each decodes its own addresses
    assign mach_acc.addr  = csr_addr;
    assign mach_acc.wdata = csr_wdata;
    assign mach_acc.write = csr_write;
    assign dbg_acc.addr   = csr_addr;
    assign dbg_acc.wdata  = csr_wdata;
    assign dbg_acc.write  = csr_write;

    assign csr_illegal = !(mach_acc.hit || dbg_acc.hit);
    assign csr_rdata   = mach_acc.hit ? mach_acc.rdata :
                         dbg_acc.hit  ? dbg_acc.rdata  : '0;

    // ebreak enable for the level the trap came from
    always_comb begin
        case (curr_priv)
            priv_csr_pkg::PRIV_M: ebreak_hit = ebreak_en[2];
            priv_csr_pkg::PRIV_S: ebreak_hit = ebreak_en[1];
            priv_csr_pkg::PRIV_U: ebreak_hit = ebreak_en[0];
            default:              ebreak_hit = 1'b0;
        endcase
    end

    assign to_debug = (trap_interrupt && trap_cause == priv_csr_pkg::CAUSE_DEBUG_HALT)
                   || (!trap_interrupt && trap_cause == priv_csr_pkg::CAUSE_BREAKPOINT
                       && ebreak_hit);
    assign running  = (mode == RUNNING);

    // nothing is captured while halted
    assign mach_trap.enter     = trap && running && !to_debug;
    assign mach_trap.epc       = trap_pc;
    assign mach_trap.cause     = trap_cause;
    assign mach_trap.interrupt = trap_interrupt;
    assign mach_trap.prv       = curr_priv;
    assign dbg_trap.enter      = trap && running && to_debug;
    assign dbg_trap.epc        = trap_pc;
    assign dbg_trap.cause      = trap_cause;
    assign dbg_trap.interrupt  = trap_interrupt;
    assign dbg_trap.prv        = curr_priv;

    always_comb begin
        nxt_mode = mode;
        nxt_pc   = redirect_pc;
        case (mode)
            RUNNING: begin
                if (trap && to_debug) begin
                    nxt_mode = HALTED;
                    nxt_pc   = DEBUG_BASE;
                end else if (trap) begin
                    nxt_pc = {mtvec[31:2], 2'b00};
                end
            end
            HALTED: begin
                if (trap) begin
                    nxt_pc = DEBUG_BASE;
                end else if (dret) begin
                    nxt_mode = RUNNING;
                    nxt_pc   = dpc;
                end
            end
            default: nxt_mode = RUNNING;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mode           <= RUNNING;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else begin
            mode           <= nxt_mode;
            redirect_valid <= trap || (!running && dret);
            redirect_pc    <= nxt_pc;
        end
    end

    assign debug_mode = (mode == HALTED);

    no_trap_dret: assert property (@(posedge CLK) disable iff (!nRST) !(trap && dret))
        else $error("trap and dret in the same cycle");

    one_enter: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({mach_trap.enter, dbg_trap.enter}))
        else $error("both CSR blocks told to capture a trap");

    // the pipeline flushes after a redirect, so no strobe follows directly
    redirect_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        redirect_valid |=> !redirect_valid)
        else $error("redirect_valid high for two cycles");

endmodule

// ==== design/trap_event_if.sv ====
`timescale 1ns/10ps

interface trap_event_if;

    // single cycle capture strobe
    logic                 enter;
    priv_csr_pkg::word_t  epc;
    priv_csr_pkg::cause_t cause;
    logic                 interrupt;
    priv_csr_pkg::priv_t  prv;

    modport router (
        output enter,
        output epc,
        output cause,
        output interrupt,
        output prv
    );

    modport csrs (
        input enter,
        input epc,
        input cause,
        input interrupt,
        input prv
    );

endinterface

// ==== sim.f ====
design/priv_csr_pkg.sv
design/csr_access_if.sv
design/trap_event_if.sv
design/priv_machine_csrs.sv
design/priv_debug_csrs.sv
design/priv_trap_router.sv
design/priv_csr_top.sv
testbench/priv_csr_tb.sv

// ==== testbench/priv_csr_tb.sv ====
`timescale 1ns/10ps

module priv_csr_tb;

    localparam priv_csr_pkg::word_t DEBUG_BASE = 32'h0000_1A00;
    localparam int NUM_CYCLES = 4000;
    localparam int REDIRECT_TIMEOUT = 4;
    // dcsr bits a write may change: ebreakm ebreaks ebreaku step prv
    localparam priv_csr_pkg::word_t DCSR_WR_BITS = 32'h0000_B007;

    logic                     CLK;
    logic                     nRST;
    priv_csr_pkg::csr_addr_t  csr_addr;
    priv_csr_pkg::word_t      csr_wdata;
    logic                     csr_write;
    logic                     trap;
    priv_csr_pkg::word_t      trap_pc;
    priv_csr_pkg::cause_t     trap_cause;
    logic                     trap_interrupt;
    priv_csr_pkg::priv_t      curr_priv;
    logic                     dret;
    priv_csr_pkg::word_t      csr_rdata;
    logic                     csr_illegal;
    logic                     redirect_valid;
    priv_csr_pkg::word_t      redirect_pc;
    logic                     debug_mode;

    // reference model state
    priv_csr_pkg::word_t      m_mtvec;
    priv_csr_pkg::word_t      m_mscratch;
    priv_csr_pkg::word_t      m_mepc;
    priv_csr_pkg::word_t      m_mcause;
    priv_csr_pkg::word_t      m_dctl;
    priv_csr_pkg::dbg_cause_t m_dcause;
    priv_csr_pkg::word_t      m_dpc;
    priv_csr_pkg::word_t      m_ds0;
    priv_csr_pkg::word_t      m_ds1;
    logic                     m_halted;
    logic                     exp_rv;
    priv_csr_pkg::word_t      exp_pc;

    priv_csr_top #(
        .DEBUG_BASE (DEBUG_BASE)
    ) dut0 (
        .CLK            (CLK),
        .nRST           (nRST),
        .csr_addr       (csr_addr),
        .csr_wdata      (csr_wdata),
        .csr_write      (csr_write),
        .trap           (trap),
        .trap_pc        (trap_pc),
        .trap_cause     (trap_cause),
        .trap_interrupt (trap_interrupt),
        .curr_priv      (curr_priv),
        .dret           (dret),
        .csr_rdata      (csr_rdata),
        .csr_illegal    (csr_illegal),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .debug_mode     (debug_mode)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input priv_csr_pkg::word_t got,
                              input priv_csr_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            fail_run("CSR read value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            fail_run("status flag mismatch");
        end
    endtask

    task automatic check_redirect(input logic got_v, input priv_csr_pkg::word_t got_pc,
                                  input logic exp_v, input priv_csr_pkg::word_t exp_pc_in);
        if (got_v !== exp_v) begin
            $display("Fail redirect_valid: got %h expected %h", got_v, exp_v);
            fail_run("redirect strobe mismatch");
        end
        if (exp_v && got_pc !== exp_pc_in) begin
            $display("Fail redirect_pc: got %h expected %h", got_pc, exp_pc_in);
            fail_run("redirect target mismatch");
        end
    endtask

    // M and U only
    function automatic logic prv_ok(input priv_csr_pkg::priv_t p);
        return (p == priv_csr_pkg::PRIV_M) || (p == priv_csr_pkg::PRIV_U);
    endfunction

    function automatic logic is_csr(input priv_csr_pkg::csr_addr_t a);
        case (a)
            priv_csr_pkg::CSR_MTVEC, priv_csr_pkg::CSR_MSCRATCH,
            priv_csr_pkg::CSR_MEPC, priv_csr_pkg::CSR_MCAUSE,
            priv_csr_pkg::CSR_DCSR, priv_csr_pkg::CSR_DPC,
            priv_csr_pkg::CSR_DSCRATCH0, priv_csr_pkg::CSR_DSCRATCH1: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic priv_csr_pkg::word_t model_read(input priv_csr_pkg::csr_addr_t a);
        priv_csr_pkg::word_t dcsr_val;
        case (a)
            priv_csr_pkg::CSR_MTVEC:     return m_mtvec;
            priv_csr_pkg::CSR_MSCRATCH:  return m_mscratch;
            priv_csr_pkg::CSR_MEPC:      return m_mepc;
            priv_csr_pkg::CSR_MCAUSE:    return m_mcause;
            priv_csr_pkg::CSR_DCSR: begin
                // xdebugver 4 on top, cause in 8:6
                dcsr_val        = m_dctl;
                dcsr_val[31:28] = 4'd4;
                dcsr_val[8:6]   = m_dcause;
                return dcsr_val;
            end
            priv_csr_pkg::CSR_DPC:       return m_dpc;
            priv_csr_pkg::CSR_DSCRATCH0: return m_ds0;
            priv_csr_pkg::CSR_DSCRATCH1: return m_ds1;
            default:                     return '0;
        endcase
    endfunction

    // mostly the eight real csrs, sometimes anything
    function automatic priv_csr_pkg::csr_addr_t pick_addr();
        case ($urandom % 12)
            0: return priv_csr_pkg::CSR_MTVEC;
            1: return priv_csr_pkg::CSR_MSCRATCH;
            2: return priv_csr_pkg::CSR_MEPC;
            3: return priv_csr_pkg::CSR_MCAUSE;
            4: return priv_csr_pkg::CSR_DCSR;
            5: return priv_csr_pkg::CSR_DPC;
            6: return priv_csr_pkg::CSR_DSCRATCH0;
            7: return priv_csr_pkg::CSR_DSCRATCH1;
            default: return priv_csr_pkg::csr_addr_t'($urandom);
        endcase
    endfunction

    function automatic priv_csr_pkg::cause_t pick_cause();
        int r;
        r = $urandom % 10;
        if (r < 4) begin
            return priv_csr_pkg::CAUSE_BREAKPOINT;
        end else if (r < 7) begin
            return priv_csr_pkg::CAUSE_DEBUG_HALT;
        end
        return priv_csr_pkg::cause_t'($urandom);
    endfunction

    // one clock edge of the model, using the inputs the DUT just sampled
    task automatic model_edge();
        logic                enter_dbg;
        logic                enter_mach;
        logic                brk_en;
        logic                halt_req;
        priv_csr_pkg::word_t nxt_ctl;
        case (curr_priv)
            priv_csr_pkg::PRIV_M: brk_en = m_dctl[15];
            priv_csr_pkg::PRIV_S: brk_en = m_dctl[13];
            priv_csr_pkg::PRIV_U: brk_en = m_dctl[12];
            default:              brk_en = 1'b0;
        endcase
        halt_req   = trap_interrupt && (trap_cause == priv_csr_pkg::CAUSE_DEBUG_HALT);
        enter_dbg  = trap && !m_halted && (halt_req || (!trap_interrupt
                     && trap_cause == priv_csr_pkg::CAUSE_BREAKPOINT && brk_en));
        enter_mach = trap && !m_halted && !enter_dbg;
        // redirect target comes from the state before the edge
        exp_rv = trap || (m_halted && dret);
        if (enter_mach) begin
            exp_pc = m_mtvec & ~32'h3;
        end else if (trap) begin
            exp_pc = DEBUG_BASE;
        end else if (m_halted && dret) begin
            exp_pc = m_dpc;
        end
        if (csr_write) begin
            case (csr_addr)
                priv_csr_pkg::CSR_MTVEC:    m_mtvec = csr_wdata & ~32'h3;
                priv_csr_pkg::CSR_MSCRATCH: m_mscratch = csr_wdata;
                priv_csr_pkg::CSR_MEPC:     m_mepc = csr_wdata & ~32'h3;
                priv_csr_pkg::CSR_MCAUSE:   m_mcause = {csr_wdata[31], 26'b0, csr_wdata[4:0]};
                priv_csr_pkg::CSR_DCSR: begin
                    nxt_ctl = (m_dctl & ~DCSR_WR_BITS) | (csr_wdata & DCSR_WR_BITS);
                    if (!prv_ok(nxt_ctl[1:0])) begin
                        nxt_ctl[1:0] = m_dctl[1:0];
                    end
                    m_dctl = nxt_ctl;
                end
                priv_csr_pkg::CSR_DPC:       m_dpc = csr_wdata;
                priv_csr_pkg::CSR_DSCRATCH0: m_ds0 = csr_wdata;
                priv_csr_pkg::CSR_DSCRATCH1: m_ds1 = csr_wdata;
                default: ;
            endcase
        end
        // trap capture overrides a write to the same fields
        if (enter_mach) begin
            m_mepc   = trap_pc & ~32'h3;
            m_mcause = {trap_interrupt, 26'b0, trap_cause};
        end
        if (enter_dbg) begin
            m_dpc    = trap_pc;
            m_dcause = halt_req ? priv_csr_pkg::DBG_CAUSE_HALTREQ
                                : priv_csr_pkg::DBG_CAUSE_EBREAK;
            if (prv_ok(curr_priv)) begin
                m_dctl[1:0] = curr_priv;
            end
            m_halted = 1'b1;
        end else if (m_halted && dret) begin
            m_halted = 1'b0;
        end
    endtask

    task automatic drive_random(input bit idle, output bit want_redirect);
        int                   kind;
        priv_csr_pkg::cause_t c;
        kind = idle ? 5 : ($urandom % 10);
        c    = pick_cause();
        csr_addr       <= pick_addr();
        csr_wdata      <= $urandom;
        // kind 7 is a trap that collides with a csr write
        csr_write      <= (kind < 4) || (kind == 7);
        trap           <= (kind == 6) || (kind == 7);
        dret           <= (kind == 8);
        trap_pc        <= $urandom;
        trap_cause     <= c;
        trap_interrupt <= (c == priv_csr_pkg::CAUSE_DEBUG_HALT) ? ($urandom % 4 != 0)
                                                                : ($urandom % 4 == 0);
        curr_priv      <= priv_csr_pkg::priv_t'($urandom % 4);
        want_redirect = (kind == 6) || (kind == 7) || ((kind == 8) && m_halted);
    endtask

    task automatic check_outputs();
        check_flag("csr_illegal", csr_illegal, !is_csr(csr_addr));
        if (is_csr(csr_addr)) begin
            check_word("csr_rdata", csr_rdata, model_read(csr_addr));
        end
        check_redirect(redirect_valid, redirect_pc, exp_rv, exp_pc);
        check_flag("debug_mode", debug_mode, m_halted);
    endtask

    task automatic tick(input bit idle, output bit want_redirect);
        @(posedge CLK);
        model_edge();
        drive_random(idle, want_redirect);
        @(negedge CLK);
        check_outputs();
    endtask

    // idle cycles until the redirect strobe shows up
    task automatic wait_redirect();
        bit unused;
        for (int i = 0; i < REDIRECT_TIMEOUT; i++) begin
            tick(1'b1, unused);
            if (redirect_valid === 1'b1) begin
                return;
            end
        end
        fail_run("redirect_valid never rose after a trap or a dret while halted");
    endtask

    initial begin
        int unsigned seed_val;
        bit          want;
        seed_val       = $urandom(32'h1996);
        nRST           = 1'b0;
        csr_addr       = '0;
        csr_wdata      = '0;
        csr_write      = 1'b0;
        trap           = 1'b0;
        trap_pc        = '0;
        trap_cause     = '0;
        trap_interrupt = 1'b0;
        curr_priv      = priv_csr_pkg::PRIV_M;
        dret           = 1'b0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_dctl     = {30'b0, priv_csr_pkg::PRIV_M};
        m_dcause   = '0;
        m_dpc      = '0;
        m_ds0      = '0;
        m_ds1      = '0;
        m_halted   = 1'b0;
        exp_rv     = 1'b0;
        exp_pc     = '0;
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            tick(1'b0, want);
            if (want) begin
                wait_redirect();
            end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule
